/* source/sdram_pkg.sv */
package sdram_pkg;

	// pin command bits are {ras_n, cas_n, we_n}
	typedef enum logic [2:0] {
		ARSR = 3'b001,
		PRCH = 3'b010,
		ACTV = 3'b011,
		WRTE = 3'b100,
		READ = 3'b101,
		NOOP = 3'b111
	} sdram_cmd_e;

	localparam int row_w  = 12;
	localparam int bank_w = 2;
	localparam int col_w  = 12;
	localparam int addr_w = row_w + bank_w + col_w; // host address width

	typedef struct packed {
		logic [row_w-1:0]  row;
		logic [bank_w-1:0] bank;
		logic [col_w-1:0]  col;
	} mem_addr_t;

	typedef struct packed {
		mem_addr_t   addr;
		logic        we;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [12:0] row;
	} pin_row_t;

	// bit 10 of the column word flags precharge or auto-precharge
	typedef struct packed {
		logic [1:0] col_hi;
		logic       auto_pre;
		logic [9:0] col_lo;
	} pin_col_t;

	typedef union packed {
		pin_row_t row_view; // ACTV
		pin_col_t col_view; // READ, WRTE, PRCH
	} pin_addr_u;

	typedef struct packed {
		sdram_cmd_e        cmd;
		logic [bank_w-1:0] bank;
		pin_addr_u         addr;
	} pin_cmd_t;

endpackage

/* source/apb_request_port.sv */
`timescale 1ns/100ps

module apb_request_port (
	input  logic                CLK,
	input  logic                RST,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [3:0]          paddr,
	input  logic [31:0]         pwdata,
	output logic [31:0]         prdata,
	output logic                pready,
	output logic                pslverr,
	output sdram_pkg::mem_req_t req,
	output logic                req_valid,
	input  logic                req_done,
	input  logic                rd_valid,
	input  logic [31:0]         rd_data
);
	import sdram_pkg::*;

	localparam logic [3:0] reg_addr  = 4'h0;
	localparam logic [3:0] reg_wdata = 4'h4;
	localparam logic [3:0] reg_ctrl  = 4'h8;
	localparam logic [3:0] reg_rdata = 4'hc;

	logic [31:0] rdata_q;
	logic        done_q;
	logic        access;
	logic        addr_ok;
	logic        ctrl_wr;
	logic        start;
	logic        complete;

	assign access = psel && penable;
	assign addr_ok = (paddr == reg_addr) || (paddr == reg_wdata) || (paddr == reg_ctrl)
		|| ((paddr == reg_rdata) && !pwrite); // rdata is read only
	assign ctrl_wr = access && pwrite && (paddr == reg_ctrl);
	assign start = ctrl_wr && !req_valid && !done_q;
	// writes finish when the command is latched, reads when data is back
	assign complete = req_valid && (req.we ? req_done : rd_valid);
	assign pready = !ctrl_wr || done_q; // stall only the ctrl write
	assign pslverr = access && !addr_ok;

	always_comb
	begin
		case (paddr)
			reg_addr:  prdata = {{(32 - addr_w){1'b0}}, req.addr};
			reg_wdata: prdata = req.wdata;
			reg_ctrl:  prdata = {31'b0, req_valid}; // busy flag
			reg_rdata: prdata = rdata_q;
			default:   prdata = '0;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			req_valid <= 1'b0;
			done_q    <= 1'b0;
		end
		else
		begin
			if (start)
				req_valid <= 1'b1;
			else if (complete)
				req_valid <= 1'b0;

			if (complete)
				done_q <= 1'b1; // releases pready next cycle
			else if (ctrl_wr && done_q)
				done_q <= 1'b0;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (access && pwrite && (paddr == reg_addr))
			req.addr <= mem_addr_t'(pwdata[addr_w-1:0]);
		if (access && pwrite && (paddr == reg_wdata))
			req.wdata <= pwdata;
		if (start)
			req.we <= pwdata[0];
		if (rd_valid)
			rdata_q <= rd_data;
	end

endmodule

/* source/sdram_timing_fsm.sv */
`timescale 1ns/100ps

module sdram_timing_fsm (
	input  logic                  CLK,
	input  logic                  RST,
	input  logic                  change_request,
	input  sdram_pkg::sdram_cmd_e next_cmd,
	input  logic                  refresh_strobe,
	output logic                  change_possible,
	output logic                  page_open,
	output logic                  refresh_time
);
	import sdram_pkg::*;

	localparam int spacing = 4; // idle cycles between commands

	sdram_cmd_e cur_cmd;
	logic [2:0] gap_cnt;
	logic       cur_is_rw;
	logic       just_taken;
	logic       refresh_ack;
	logic       fast_change;
	logic       take;

	// repeated read or write on the open row skips the spacing
	assign fast_change = cur_is_rw && page_open && (next_cmd == cur_cmd) && !just_taken;
	assign change_possible = (gap_cnt == 3'd0) || fast_change;
	assign take = change_possible && change_request && (next_cmd != NOOP);
	assign refresh_time = refresh_ack ^ refresh_strobe; // strobe toggled

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			cur_cmd     <= NOOP;
			gap_cnt     <= 3'd0;
			cur_is_rw   <= 1'b0;
			just_taken  <= 1'b0;
			page_open   <= 1'b0;
			refresh_ack <= refresh_strobe;
		end
		else
		begin
			just_taken <= take;

			if (take)
			begin
				cur_cmd   <= next_cmd;
				cur_is_rw <= (next_cmd == READ) || (next_cmd == WRTE);
				gap_cnt   <= 3'(spacing);

				case (next_cmd)
					ACTV:
					begin
						page_open <= 1'b1;
					end
					PRCH:
					begin
						page_open <= 1'b0;
					end
					ARSR:
					begin
						refresh_ack <= refresh_strobe; // refresh served
					end
					default:
					begin
						page_open <= page_open;
					end
				endcase
			end
			else if (gap_cnt != 3'd0)
			begin
				gap_cnt <= gap_cnt - 3'd1;
			end
		end
	end

endmodule

/* source/sdram_command_select.sv */
`timescale 1ns/100ps

module sdram_command_select #(
	parameter int act_guard = 4
) (
	input  logic                  CLK,
	input  logic                  RST,
	input  sdram_pkg::mem_req_t   req,
	input  logic                  req_valid,
	input  logic                  change_possible,
	input  logic                  page_open,
	input  logic                  refresh_time,
	output logic                  change_request,
	output sdram_pkg::sdram_cmd_e next_cmd,
	output logic                  cmd_latched,
	output logic                  req_done,
	output sdram_pkg::pin_cmd_t   mem_cmd
);
	import sdram_pkg::*;

	localparam int guard_w = $clog2(act_guard + 1);
	localparam logic [guard_w-1:0] guard_max = guard_w'(act_guard);

	logic [row_w-1:0]   open_row;
	logic [bank_w-1:0]  open_bank;
	logic [guard_w-1:0] open_cnt;
	logic               served;
	logic               req_pending;
	logic               row_hit;
	logic               rw_sel;
	logic               latch;
	pin_addr_u          act_addr;
	pin_addr_u          rw_addr;
	pin_addr_u          pre_addr;
	pin_cmd_t           pin_next;

	// a read stays valid until its data returns, so mark it served
	assign req_pending = req_valid && !served;
	assign row_hit = page_open && !refresh_time && (req.addr.row == open_row)
		&& (req.addr.bank == open_bank);
	assign rw_sel = req_pending && row_hit;
	assign change_request = req_pending || refresh_time;
	assign latch = change_possible && change_request && (next_cmd != NOOP);
	assign cmd_latched = latch && rw_sel;
	assign req_done = cmd_latched && req.we;

	assign act_addr.row_view.row = {1'b0, req.addr.row};
	assign rw_addr.col_view = '{col_hi: req.addr.col[11:10], auto_pre: 1'b0,
		col_lo: req.addr.col[9:0]};
	assign pre_addr.col_view = '{col_hi: 2'b00, auto_pre: 1'b1, col_lo: 10'h000}; // all banks

	always_comb
	begin
		if (rw_sel)
		begin
			if (req.we)
				next_cmd = WRTE;
			else
				next_cmd = READ;
		end
		else if (page_open)
		begin
			if (open_cnt == guard_max)
				next_cmd = PRCH; // close page for miss or refresh
			else
				next_cmd = NOOP;
		end
		else if (refresh_time)
			next_cmd = ARSR;
		else
			next_cmd = ACTV;
	end

	always_comb
	begin
		pin_next.cmd  = next_cmd;
		pin_next.bank = req.addr.bank;
		case (next_cmd)
			ACTV:
				pin_next.addr = act_addr;
			READ, WRTE:
				pin_next.addr = rw_addr;
			default:
			begin
				pin_next.bank = open_bank;
				pin_next.addr = pre_addr;
			end
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			mem_cmd.cmd  <= NOOP;
			mem_cmd.bank <= '0;
			mem_cmd.addr <= pre_addr;
			open_row     <= '0;
			open_bank    <= '0;
			open_cnt     <= '0;
			served       <= 1'b0;
		end
		else
		begin
			served <= req_valid && (served || cmd_latched);

			if (latch)
				mem_cmd <= pin_next;
			else
				mem_cmd.cmd <= NOOP; // address holds

			if (latch && (next_cmd == ACTV))
			begin
				open_row  <= req.addr.row;
				open_bank <= req.addr.bank;
				open_cnt  <= '0; // row open time starts
			end
			else if (open_cnt != guard_max)
			begin
				open_cnt <= open_cnt + 1'b1;
			end
		end
	end

endmodule

/* source/sdram_data_path.sv */
`timescale 1ns/100ps

module sdram_data_path #(
	parameter int cas_latency = 3
) (
	input  logic        CLK,
	input  logic        RST,
	input  logic        cmd_latched,
	input  logic        we,
	input  logic [31:0] wdata,
	input  logic [31:0] mem_dq_in,
	output logic [31:0] mem_dq_out,
	output logic        mem_dq_oe,
	output logic [31:0] rd_data,
	output logic        rd_valid
);

	logic [cas_latency:0] rd_pipe; // one marker per read in flight
	logic                 wr_fire;
	logic                 rd_fire;

	assign wr_fire = cmd_latched && we;
	assign rd_fire = cmd_latched && !we;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			rd_pipe   <= '0;
			rd_valid  <= 1'b0;
			mem_dq_oe <= 1'b0;
		end
		else
		begin
			// marker reaches the top when the model drives data
			rd_pipe   <= {rd_pipe[cas_latency-1:0], rd_fire};
			rd_valid  <= rd_pipe[cas_latency];
			mem_dq_oe <= wr_fire; // same cycle as WRTE on pins
		end
	end

	always_ff @(posedge CLK)
	begin
		if (wr_fire)
			mem_dq_out <= wdata;
		if (rd_pipe[cas_latency])
			rd_data <= mem_dq_in;
	end

endmodule

/* source/sdram_ctrl_top.sv */
`timescale 1ns/100ps

module sdram_ctrl_top #(
	parameter int cas_latency = 3,
	parameter int act_guard   = 4
) (
	input  logic                CLK,
	input  logic                RST,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [3:0]          paddr,
	input  logic [31:0]         pwdata,
	output logic [31:0]         prdata,
	output logic                pready,
	output logic                pslverr,
	input  logic                refresh_strobe,
	output sdram_pkg::pin_cmd_t mem_cmd,
	output logic [31:0]         mem_dq_out,
	output logic                mem_dq_oe,
	input  logic [31:0]         mem_dq_in
);
	import sdram_pkg::*;

	mem_req_t    req;
	logic        req_valid;
	logic        req_done;
	logic        rd_valid;
	logic [31:0] rd_data;
	logic        change_possible;
	logic        page_open;
	logic        refresh_time;
	logic        change_request;
	sdram_cmd_e  next_cmd;
	logic        cmd_latched;

	apb_request_port u_apb_port (
		.CLK       (CLK),
		.RST       (RST),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.req       (req),
		.req_valid (req_valid),
		.req_done  (req_done),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data)
	);

	sdram_timing_fsm u_timing (
		.CLK             (CLK),
		.RST             (RST),
		.change_request  (change_request),
		.next_cmd        (next_cmd),
		.refresh_strobe  (refresh_strobe),
		.change_possible (change_possible),
		.page_open       (page_open),
		.refresh_time    (refresh_time)
	);

	sdram_command_select #(
		.act_guard (act_guard)
	) u_cmd_select (
		.CLK             (CLK),
		.RST             (RST),
		.req             (req),
		.req_valid       (req_valid),
		.change_possible (change_possible),
		.page_open       (page_open),
		.refresh_time    (refresh_time),
		.change_request  (change_request),
		.next_cmd        (next_cmd),
		.cmd_latched     (cmd_latched),
		.req_done        (req_done),
		.mem_cmd         (mem_cmd)
	);

	sdram_data_path #(
		.cas_latency (cas_latency)
	) u_data_path (
		.CLK         (CLK),
		.RST         (RST),
		.cmd_latched (cmd_latched),
		.we          (req.we),
		.wdata       (req.wdata),
		.mem_dq_in   (mem_dq_in),
		.mem_dq_out  (mem_dq_out),
		.mem_dq_oe   (mem_dq_oe),
		.rd_data     (rd_data),
		.rd_valid    (rd_valid)
	);

endmodule

/* bench/sdram_bench_clock.sv */
`timescale 1ns/100ps

module sdram_bench_clock #(
	parameter int period_ns    = 20,
	parameter int reset_cycles = 16
) (
	output logic CLK,
	output logic RST
);

	initial
	begin
		CLK = 1'b0;
		forever #(period_ns / 2) CLK = ~CLK;
	end

	initial
	begin
		RST = 1'b0; // active low
		repeat (reset_cycles) @(posedge CLK);
		RST <= 1'b1;
	end

endmodule

/* bench/sdram_mem_model.sv */
`timescale 1ns/100ps

module sdram_mem_model #(
	parameter int cas_latency = 3
) (
	input  logic                CLK,
	input  logic                RST,
	input  sdram_pkg::pin_cmd_t mem_cmd,
	input  logic [31:0]         mem_dq_out,
	input  logic                mem_dq_oe,
	output logic [31:0]         mem_dq_in,
	output logic                protocol_error
);
	import sdram_pkg::*;

	logic [31:0]            cells[logic [25:0]]; // written words only
	logic [3:0]             bank_open;
	logic [11:0]            open_row[4];
	logic [cas_latency-1:0] rd_v = '0; // read data delay line
	logic [31:0]            rd_d[cas_latency];
	logic [11:0]            col;
	logic [25:0]            cell_addr;

	// unwritten words return a pattern of their address
	function automatic logic [31:0] fill_word(input logic [25:0] a);
		return {a[5:0], a} ^ 32'h9e37_79b9;
	endfunction

	task automatic flag_error(input string what);
		$display("memory model: %s, bank %0d", what, mem_cmd.bank);
		protocol_error <= 1'b1;
	endtask

	assign col = {mem_cmd.addr.col_view.col_hi, mem_cmd.addr.col_view.col_lo};
	assign cell_addr = {open_row[mem_cmd.bank], mem_cmd.bank, col};
	assign mem_dq_in = rd_v[cas_latency-1] ? rd_d[cas_latency-1] : 32'h0;

	always @(posedge CLK)
	begin
		if (!RST)
		begin
			bank_open      <= '0;
			protocol_error <= 1'b0;
			rd_v           <= '0;
		end
		else
		begin
			for (int i = cas_latency - 1; i > 0; i--)
			begin
				rd_v[i] <= rd_v[i-1];
				rd_d[i] <= rd_d[i-1];
			end
			rd_v[0] <= 1'b0;
			case (mem_cmd.cmd)
				ACTV:
				begin
					if (bank_open[mem_cmd.bank])
						flag_error("ACTV to a bank that already has an open row");
					bank_open[mem_cmd.bank] <= 1'b1;
					open_row[mem_cmd.bank]  <= mem_cmd.addr.row_view.row[11:0];
				end
				PRCH:
				begin
					if (mem_cmd.addr.col_view.auto_pre)
						bank_open <= '0; // all banks
					else
						bank_open[mem_cmd.bank] <= 1'b0;
				end
				ARSR:
				begin
					if (bank_open != '0)
						flag_error("auto refresh while a row is still open");
				end
				WRTE:
				begin
					if (!bank_open[mem_cmd.bank])
						flag_error("WRTE to a bank with no active row");
					else if (!mem_dq_oe)
						flag_error("WRTE without write data driven");
					else
						cells[cell_addr] = mem_dq_out;
				end
				READ:
				begin
					if (!bank_open[mem_cmd.bank])
						flag_error("READ to a bank with no active row");
					rd_v[0] <= 1'b1;
					rd_d[0] <= cells.exists(cell_addr) ? cells[cell_addr] : fill_word(cell_addr);
				end
				default:
				begin
				end
			endcase
		end
	end

endmodule

/* bench/sdram_ctrl_tb.sv */
`timescale 1ns/100ps

module sdram_ctrl_tb;
	import sdram_pkg::*;

	localparam int cas_latency   = 3;
	localparam int act_guard     = 4;
	localparam int apb_limit     = 100; // cycles per APB access
	localparam int refresh_limit = 60;
	localparam int reset_limit   = 40;
	localparam logic [3:0] reg_addr  = 4'h0;
	localparam logic [3:0] reg_wdata = 4'h4;
	localparam logic [3:0] reg_ctrl  = 4'h8;
	localparam logic [3:0] reg_rdata = 4'hc;

	logic        CLK;
	logic        RST;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        refresh_strobe;
	pin_cmd_t    mem_cmd;
	logic [31:0] mem_dq_out;
	logic        mem_dq_oe;
	logic [31:0] mem_dq_in;
	logic        protocol_error;
	pin_cmd_t    cmd_log[$];         // non-NOOP pin commands
	logic [31:0] shadow[logic [25:0]]; // expected memory contents
	mem_addr_t   addr_a;
	mem_addr_t   addr_b;

	sdram_bench_clock #(
		.period_ns    (20),
		.reset_cycles (16)
	) u_clock (
		.CLK (CLK),
		.RST (RST)
	);

	sdram_ctrl_top #(
		.cas_latency (cas_latency),
		.act_guard   (act_guard)
	) u_dut (
		.CLK            (CLK),
		.RST            (RST),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.paddr          (paddr),
		.pwdata         (pwdata),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr),
		.refresh_strobe (refresh_strobe),
		.mem_cmd        (mem_cmd),
		.mem_dq_out     (mem_dq_out),
		.mem_dq_oe      (mem_dq_oe),
		.mem_dq_in      (mem_dq_in)
	);

	sdram_mem_model #(
		.cas_latency (cas_latency)
	) u_mem (
		.CLK            (CLK),
		.RST            (RST),
		.mem_cmd        (mem_cmd),
		.mem_dq_out     (mem_dq_out),
		.mem_dq_oe      (mem_dq_oe),
		.mem_dq_in      (mem_dq_in),
		.protocol_error (protocol_error)
	);

	task automatic stop_with_failure();
		$display("Test failures found");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1)
		else
		begin
			$display("%s", what);
			stop_with_failure();
		end
	endtask

	// commands sampled mid-cycle
	always @(negedge CLK)
	begin
		if (RST)
		begin
			if (mem_cmd.cmd != NOOP)
				cmd_log.push_back(mem_cmd);
			check_true(!protocol_error, "memory model saw an illegal command sequence");
		end
	end

	function automatic logic [11:0] pin_column(input pin_cmd_t c);
		return {c.addr.col_view.col_hi, c.addr.col_view.col_lo};
	endfunction

	task automatic apb_transfer(input logic wr, input logic [3:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr);
		int waited;
		@(posedge CLK);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge CLK);
		penable <= 1'b1; // access phase
		waited = 0;
		@(posedge CLK);
		while (!pready)
		begin
			waited++;
			check_true(waited < apb_limit, "timeout waiting for pready");
			@(posedge CLK);
		end
		rdata = prdata;
		slverr = pslverr;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
		output logic slverr);
		logic [31:0] unused;
		apb_transfer(1'b1, addr, data, unused, slverr);
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
		output logic slverr);
		apb_transfer(1'b0, addr, 32'h0, data, slverr);
	endtask

	task automatic pulse_refresh();
		int   waited;
		logic found;
		@(posedge CLK);
		refresh_strobe <= ~refresh_strobe; // toggle requests one refresh
		waited = 0;
		found = 1'b0;
		while (!found)
		begin
			@(negedge CLK);
			found = (cmd_log.size() > 0) && (cmd_log[$].cmd == ARSR);
			waited++;
			check_true(found || (waited < refresh_limit), "timeout waiting for ARSR");
		end
	endtask

	task automatic mem_write(input mem_addr_t a, input logic [31:0] data);
		logic err;
		apb_write(reg_addr, {6'b0, a}, err);
		check_value("pslverr", err, 1'b0);
		apb_write(reg_wdata, data, err);
		check_value("pslverr", err, 1'b0);
		apb_write(reg_ctrl, 32'h1, err); // we set
		check_value("pslverr", err, 1'b0);
		shadow[a] = data;
	endtask

	task automatic check_read(input mem_addr_t a);
		logic        err;
		logic [31:0] data;
		apb_write(reg_addr, {6'b0, a}, err);
		check_value("pslverr", err, 1'b0);
		apb_write(reg_ctrl, 32'h0, err);
		check_value("pslverr", err, 1'b0);
		apb_read(reg_rdata, data, err);
		check_value("pslverr", err, 1'b0);
		check_true(shadow.exists(a), "read of an address that was never written");
		check_value("RDATA", data, shadow[a]);
	endtask

	task automatic expect_cmd(input int idx, input sdram_cmd_e cmd);
		check_true(idx < cmd_log.size(), $sformatf("pin command %0d never appeared", idx));
		check_value($sformatf("mem_cmd.cmd[%0d]", idx), cmd_log[idx].cmd, cmd);
	endtask

	task automatic check_reset_state();
		logic        err;
		logic [31:0] data;
		@(negedge CLK);
		check_value("mem_cmd.cmd", mem_cmd.cmd, NOOP);
		check_value("mem_cmd.addr", mem_cmd.addr, 13'h400);
		check_value("mem_dq_oe", mem_dq_oe, 1'b0);
		check_value("pready", pready, 1'b1);
		apb_write(4'h2, 32'h1234_5678, err); // unmapped
		check_value("pslverr", err, 1'b1);
		apb_write(reg_rdata, 32'h0, err); // read only
		check_value("pslverr", err, 1'b1);
		apb_read(4'h6, data, err);
		check_value("pslverr", err, 1'b1);
		apb_write(reg_wdata, 32'h0, err);
		check_value("pslverr", err, 1'b0);
		check_value("command count", cmd_log.size(), 0);
	endtask

	task automatic check_page_hit();
		addr_a = '{row: 12'h0a5, bank: 2'd1, col: 12'h123};
		cmd_log.delete();
		mem_write(addr_a, 32'hcafe_0001);
		check_read(addr_a);
		check_value("command count", cmd_log.size(), 3); // one ACTV only
		expect_cmd(0, ACTV);
		expect_cmd(1, WRTE);
		expect_cmd(2, READ);
		check_value("ACTV row", cmd_log[0].addr.row_view.row, {1'b0, addr_a.row});
		check_value("ACTV bank", cmd_log[0].bank, addr_a.bank);
		check_value("WRTE column", pin_column(cmd_log[1]), addr_a.col);
		check_value("WRTE auto_pre", cmd_log[1].addr.col_view.auto_pre, 1'b0);
		check_value("READ column", pin_column(cmd_log[2]), addr_a.col);
		check_value("READ bank", cmd_log[2].bank, addr_a.bank);
	endtask

	task automatic check_row_miss();
		addr_b = '{row: 12'h3c7, bank: 2'd2, col: 12'hb0f};
		cmd_log.delete();
		mem_write(addr_b, 32'h5eed_b00c);
		check_value("command count", cmd_log.size(), 3);
		expect_cmd(0, PRCH);
		check_value("PRCH auto_pre", cmd_log[0].addr.col_view.auto_pre, 1'b1);
		expect_cmd(1, ACTV);
		check_value("ACTV row", cmd_log[1].addr.row_view.row, {1'b0, addr_b.row});
		check_value("ACTV bank", cmd_log[1].bank, addr_b.bank);
		expect_cmd(2, WRTE);
		check_value("WRTE column", pin_column(cmd_log[2]), addr_b.col);
		check_read(addr_b);
		expect_cmd(3, READ);
	endtask

	task automatic check_refresh();
		cmd_log.delete();
		pulse_refresh();
		check_value("command count", cmd_log.size(), 2);
		expect_cmd(0, PRCH); // page was open
		check_value("PRCH auto_pre", cmd_log[0].addr.col_view.auto_pre, 1'b1);
		expect_cmd(1, ARSR);
		cmd_log.delete();
		check_read(addr_b);
		check_value("command count", cmd_log.size(), 2);
		expect_cmd(0, ACTV); // page closed by refresh
		check_value("ACTV row", cmd_log[0].addr.row_view.row, {1'b0, addr_b.row});
		expect_cmd(1, READ);
		check_read(addr_a);
	endtask

	task automatic check_random_traffic();
		mem_addr_t addrs[8];
		int        order[8];
		int        j;
		int        tmp;
		for (int i = 0; i < 8; i++)
		begin
			addrs[i] = mem_addr_t'(26'($urandom()));
			while (shadow.exists(addrs[i]))
				addrs[i] = mem_addr_t'(26'($urandom()));
			mem_write(addrs[i], $urandom());
			order[i] = i;
		end
		for (int i = 7; i > 0; i--)
		begin
			j = $urandom_range(i, 0);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < 8; i++)
		begin
			cmd_log.delete();
			check_read(addrs[order[i]]);
			check_true(cmd_log.size() > 0, "no pin command seen for a read");
			check_value("last mem_cmd.cmd", cmd_log[$].cmd, READ);
			check_value("READ bank", cmd_log[$].bank, addrs[order[i]].bank);
			check_value("READ column", pin_column(cmd_log[$]), addrs[order[i]].col);
		end
	endtask

	initial
	begin
		int waited;
		void'($urandom(32'h41a));
		psel           = 1'b0;
		penable        = 1'b0;
		pwrite         = 1'b0;
		paddr          = 4'h0;
		pwdata         = 32'h0;
		refresh_strobe = 1'b0;
		waited = 0;
		while (RST !== 1'b1)
		begin
			@(posedge CLK);
			waited++;
			check_true(waited < reset_limit, "timeout waiting for reset release");
		end
		check_reset_state();
		check_page_hit();
		check_row_miss();
		check_refresh();
		check_random_traffic();
		@(negedge CLK);
		if (!protocol_error)
		begin
			$display("All tests passed!");
			$finish;
		end
		else
		begin
			$display("memory model flagged an error at the end of the run");
			stop_with_failure();
		end
	end

endmodule

/* sdram_ctrl_top.f */
source/sdram_pkg.sv
source/apb_request_port.sv
source/sdram_timing_fsm.sv
source/sdram_command_select.sv
source/sdram_data_path.sv
source/sdram_ctrl_top.sv
bench/sdram_bench_clock.sv
bench/sdram_mem_model.sv
bench/sdram_ctrl_tb.sv

/* Bender.yml */
package:
  name: sdram_ctrl

sources:
  - source/sdram_pkg.sv
  - source/apb_request_port.sv
  - source/sdram_timing_fsm.sv
  - source/sdram_command_select.sv
  - source/sdram_data_path.sv
  - source/sdram_ctrl_top.sv
  - target: simulation
    files:
      - bench/sdram_bench_clock.sv
      - bench/sdram_mem_model.sv
      - bench/sdram_ctrl_tb.sv
